/* design/action_table.sv */
// action_table: DEPTH x ACT_W action memory, synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none

module action_table
    import lookup_pkg::*;
(
    input  wire logic clk,
    input  wire logic we,
    input  wire idx_t wr_idx,
    input  wire act_t wr_data,
    input  wire idx_t rd_idx,
    output act_t      rd_data
);

    act_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

/* design/cam_cell.sv */
// cam_cell: single CAM entry holding a key and valid bit, with a masked compare
`timescale 1ns/1ps
`default_nettype none

module cam_cell
    import lookup_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic we,
    input  wire key_t wr_key,
    input  wire key_t search_key,
    input  wire key_t search_mask,
    output logic      hit
);

    key_t entry_key;
    logic entry_valid;
    key_t diff;

    // entry becomes live on its first write and stays live
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= 1'b0;
        end else if (we) begin
            entry_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entry_key <= wr_key;
        end
    end

    // only bits selected by the mask take part
    assign diff = (entry_key ^ search_key) & search_mask;
    assign hit  = entry_valid && (diff == '0);

endmodule

`default_nettype wire

/* design/lookup_ctrl.sv */
// lookup_ctrl: lookup FSM, PHV capture and output valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module lookup_ctrl
    import lookup_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,

    // from the key extractor
    input  wire logic key_valid,
    input  wire phv_t phv_in,
    output logic      ready_out,

    // encoder result and action memory data
    input  wire logic match,
    input  wire act_t act_rd_data,

    // to the action stage
    output logic      action_valid,
    output act_t      action,
    output phv_t      phv_out,
    input  wire logic ready_in
);

    lkp_state_t state;
    logic       match_wait;
    logic       accept;
    logic       miss_done;

    assign accept = (state == LKP_IDLE) && key_valid && ready_out;

    // encoder output reflects the accepted key one edge after accept
    assign miss_done = (state == LKP_MATCH) && !match_wait && !match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LKP_IDLE;
            ready_out    <= 1'b1;
            action_valid <= 1'b0;
            match_wait   <= 1'b0;
        end else begin
            case (state)
                LKP_IDLE: begin
                    if (accept) begin
                        ready_out  <= 1'b0;
                        match_wait <= 1'b1;
                        state      <= LKP_MATCH;
                    end
                end
                LKP_MATCH: begin
                    if (match_wait) begin
                        match_wait <= 1'b0;
                    end else if (match) begin
                        // action memory is reading match_idx this cycle
                        state <= LKP_READ;
                    end else begin
                        action_valid <= 1'b1;
                        state        <= LKP_HOLD;
                    end
                end
                LKP_READ: begin
                    action_valid <= 1'b1;
                    state        <= LKP_HOLD;
                end
                LKP_HOLD: begin
                    if (ready_in) begin
                        action_valid <= 1'b0;
                        ready_out    <= 1'b1;
                        state        <= LKP_IDLE;
                    end
                end
                default: state <= LKP_IDLE;
            endcase
        end
    end

    // phv_out is the capture register, it only moves on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_out <= phv_in;
        end
        if (miss_done) begin
            action <= DEFAULT_ACT;
        end else if (state == LKP_READ) begin
            action <= act_rd_data;
        end
    end

endmodule

`default_nettype wire

/* design/lookup_engine.sv */
// lookup_engine: match-action stage top with config parser, CAM cells, encoder, action table, FSM
`timescale 1ns/1ps
`default_nettype none

module lookup_engine
    import lookup_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,

    // lookup request
    input  wire logic key_valid,
    input  wire key_t search_key,
    input  wire key_t search_mask,
    input  wire phv_t phv_in,
    output logic      ready_out,

    // lookup result
    output logic      action_valid,
    output act_t      action,
    output phv_t      phv_out,
    input  wire logic ready_in,

    // control stream
    input  wire logic cfg_in_valid,
    input  wire cfg_t cfg_in_data,
    input  wire logic cfg_in_last,
    output logic      cfg_out_valid,
    output cfg_t      cfg_out_data,
    output logic      cfg_out_last
);

    hit_vec_t cam_we;
    key_t     cam_wr_key;
    logic     act_we;
    idx_t     act_wr_idx;
    act_t     act_wr_data;

    hit_vec_t hits;
    logic     match;
    idx_t     match_idx;
    act_t     act_rd_data;

    table_config u_table_config (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_in_valid  (cfg_in_valid),
        .cfg_in_data   (cfg_in_data),
        .cfg_in_last   (cfg_in_last),
        .cfg_out_valid (cfg_out_valid),
        .cfg_out_data  (cfg_out_data),
        .cfg_out_last  (cfg_out_last),
        .cam_we        (cam_we),
        .cam_wr_key    (cam_wr_key),
        .act_we        (act_we),
        .act_wr_idx    (act_wr_idx),
        .act_wr_data   (act_wr_data)
    );

    // one cell per entry, each owns one bit of the hit vector
    for (genvar i = 0; i < DEPTH; i++) begin : g_cell
        cam_cell u_cam_cell (
            .clk         (clk),
            .rst_n       (rst_n),
            .we          (cam_we[i]),
            .wr_key      (cam_wr_key),
            .search_key  (search_key),
            .search_mask (search_mask),
            .hit         (hits[i])
        );
    end

    match_encoder u_match_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .hits      (hits),
        .match     (match),
        .match_idx (match_idx)
    );

    action_table u_action_table (
        .clk     (clk),
        .we      (act_we),
        .wr_idx  (act_wr_idx),
        .wr_data (act_wr_data),
        .rd_idx  (match_idx),
        .rd_data (act_rd_data)
    );

    lookup_ctrl u_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .ready_out    (ready_out),
        .match        (match),
        .act_rd_data  (act_rd_data),
        .action_valid (action_valid),
        .action       (action),
        .phv_out      (phv_out),
        .ready_in     (ready_in)
    );

endmodule

`default_nettype wire

/* design/lookup_pkg.sv */
// lookup_pkg: widths, control header field positions, constants, vector types and FSM states
`default_nettype none

package lookup_pkg;

    // datapath widths
    localparam int KEY_W = 32;
    localparam int ACT_W = 32;
    localparam int PHV_W = 64;
    localparam int DEPTH = 16;
    localparam int IDX_W = 4;
    localparam int CFG_W = 64;

    // control stream identification
    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;
    localparam logic [4:0]  STAGE_ID  = 5'd0;
    localparam logic [2:0]  LOOKUP_ID = 3'd2;
    localparam logic [7:0]  MOD_ID    = {STAGE_ID, LOOKUP_ID};

    // action returned when nothing in the CAM hits
    localparam logic [ACT_W-1:0] DEFAULT_ACT = 32'h3f;

    // header beat layout
    localparam int FLAG_LO  = 48;
    localparam int FLAG_W   = 16;
    localparam int MODID_LO = 40;
    localparam int MODID_W  = 8;
    localparam int KIND_LO  = 36;
    localparam int KIND_W   = 4;
    localparam int INDEX_LO = 32;

    typedef logic [KEY_W-1:0] key_t;
    typedef logic [ACT_W-1:0] act_t;
    typedef logic [PHV_W-1:0] phv_t;
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CFG_W-1:0] cfg_t;
    typedef logic [DEPTH-1:0] hit_vec_t;

    typedef enum logic [1:0] {CFG_IDLE, CFG_CAM, CFG_ACT, CFG_FWD} cfg_state_t;
    typedef enum logic [1:0] {LKP_IDLE, LKP_MATCH, LKP_READ, LKP_HOLD} lkp_state_t;

endpackage

`default_nettype wire

/* design/match_encoder.sv */
// match_encoder: registered lowest-index priority encoder over the CAM hit vector
`timescale 1ns/1ps
`default_nettype none

module match_encoder
    import lookup_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire hit_vec_t hits,
    output logic          match,
    output idx_t          match_idx
);

    logic any_hit;
    idx_t first_idx;

    // scan from the top down so the lowest set bit wins
    always_comb begin
        any_hit   = 1'b0;
        first_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hits[i]) begin
                any_hit   = 1'b1;
                first_idx = idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match     <= 1'b0;
            match_idx <= '0;
        end else begin
            match     <= any_hit;
            match_idx <= first_idx;
        end
    end

endmodule

`default_nettype wire

/* design/table_config.sv */
// table_config: control stream parser, CAM and action entry writer, foreign packet forwarder
`timescale 1ns/1ps
`default_nettype none

module table_config
    import lookup_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,

    // control stream in
    input  wire logic cfg_in_valid,
    input  wire cfg_t cfg_in_data,
    input  wire logic cfg_in_last,

    // control stream out, foreign packets only
    output logic      cfg_out_valid,
    output cfg_t      cfg_out_data,
    output logic      cfg_out_last,

    // table write side
    output hit_vec_t  cam_we,
    output key_t      cam_wr_key,
    output logic      act_we,
    output idx_t      act_wr_idx,
    output act_t      act_wr_data
);

    cfg_state_t state;
    idx_t       entry_idx;

    logic [FLAG_W-1:0]  hdr_flag;
    logic [MODID_W-1:0] hdr_mod;
    logic [KIND_W-1:0]  hdr_kind;
    idx_t               hdr_index;
    logic               hdr_ours;

    assign hdr_flag  = cfg_in_data[FLAG_LO +: FLAG_W];
    assign hdr_mod   = cfg_in_data[MODID_LO +: MODID_W];
    assign hdr_kind  = cfg_in_data[KIND_LO +: KIND_W];
    assign hdr_index = cfg_in_data[INDEX_LO +: IDX_W];
    assign hdr_ours  = (hdr_flag == CTRL_FLAG) && (hdr_mod == MOD_ID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= CFG_IDLE;
            entry_idx     <= '0;
            cam_we        <= '0;
            act_we        <= 1'b0;
            cfg_out_valid <= 1'b0;
            cfg_out_last  <= 1'b0;
        end else begin
            // strobes last a single cycle
            cam_we        <= '0;
            act_we        <= 1'b0;
            cfg_out_valid <= 1'b0;
            cfg_out_last  <= 1'b0;

            if (cfg_in_valid) begin
                case (state)
                    CFG_IDLE: begin
                        if (hdr_ours) begin
                            entry_idx <= hdr_index;
                            // header-only packet writes nothing
                            if (!cfg_in_last) begin
                                state <= (hdr_kind == '0) ? CFG_CAM : CFG_ACT;
                            end
                        end else begin
                            cfg_out_valid <= 1'b1;
                            cfg_out_last  <= cfg_in_last;
                            if (!cfg_in_last) begin
                                state <= CFG_FWD;
                            end
                        end
                    end
                    CFG_CAM: begin
                        cam_we    <= hit_vec_t'(1) << entry_idx;
                        entry_idx <= entry_idx + 1'b1;
                        if (cfg_in_last) begin
                            state <= CFG_IDLE;
                        end
                    end
                    CFG_ACT: begin
                        act_we    <= 1'b1;
                        entry_idx <= entry_idx + 1'b1;
                        if (cfg_in_last) begin
                            state <= CFG_IDLE;
                        end
                    end
                    CFG_FWD: begin
                        cfg_out_valid <= 1'b1;
                        cfg_out_last  <= cfg_in_last;
                        if (cfg_in_last) begin
                            state <= CFG_IDLE;
                        end
                    end
                    default: state <= CFG_IDLE;
                endcase
            end
        end
    end

    // payload follows the input, qualified by the strobes above
    always_ff @(posedge clk) begin
        cfg_out_data <= cfg_in_data;
        cam_wr_key   <= cfg_in_data[KEY_W-1:0];
        act_wr_data  <= cfg_in_data[ACT_W-1:0];
        act_wr_idx   <= entry_idx;
    end

endmodule

`default_nettype wire

/* project.f */
design/lookup_pkg.sv
design/cam_cell.sv
design/match_encoder.sv
design/table_config.sv
design/action_table.sv
design/lookup_ctrl.sv
design/lookup_engine.sv
tb/tb_clock.sv
tb/tb_lookup_engine.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_lookup_engine -Mdir obj_dir
./obj_dir/Vtb_lookup_engine

/* tb/tb_clock.sv */
// tb_clock: free-running testbench clock and power-on reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 2;
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_lookup_engine.sv */
// tb_lookup_engine: stimulus, table model, assertions and watchdog for the lookup stage
`timescale 1ns/1ps
`default_nettype none

module tb_lookup_engine
    import lookup_pkg::*;
();

    localparam int CLK_PERIOD_NS  = 4;
    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + 100;
    localparam int WAIT_LIMIT     = 50;

    logic clk, rst_n;
    logic key_valid, ready_out, action_valid, ready_in;
    key_t search_key, search_mask;
    phv_t phv_in, phv_out;
    act_t action;
    logic cfg_in_valid, cfg_in_last, cfg_out_valid, cfg_out_last;
    cfg_t cfg_in_data, cfg_out_data;

    // reference tables, filled from the packets that are sent
    key_t        model_key [DEPTH];
    logic        model_valid [DEPTH];
    act_t        model_act [DEPTH];
    logic [31:0] words [4];
    logic [31:0] lcg_state;

    act_t       exp_action;
    phv_t       exp_phv;
    logic [7:0] exp_latency, since_accept;
    logic       cfg_in_foreign, exp_out_valid, exp_out_last;
    cfg_t       exp_out_data;

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

    lookup_engine dut0 (.*);

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] t=%0t %s", $time, what);
        stop_run();
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // lowest valid entry that agrees with the key on every masked bit
    task automatic predict(input key_t key, input key_t mask, output logic hit, output idx_t idx);
        hit = 1'b0;
        idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!hit && model_valid[i] && (((model_key[i] ^ key) & mask) == '0)) begin
                hit = 1'b1;
                idx = idx_t'(i);
            end
        end
    endtask

    // foreign beats reappear one cycle later, accept edge restarts the counter
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_out_valid <= 1'b0;
            exp_out_data  <= '0;
            exp_out_last  <= 1'b0;
            since_accept  <= 8'hff;
        end else begin
            exp_out_valid <= cfg_in_valid && cfg_in_foreign;
            exp_out_data  <= cfg_in_data;
            exp_out_last  <= cfg_in_last;
            if (key_valid && ready_out) begin
                since_accept <= 8'd0;
            end else if (since_accept != 8'hff) begin
                since_accept <= since_accept + 8'd1;
            end
        end
    end

    // outputs are checked on the falling edge, half a cycle after they move
    a_latency: assert property (@(negedge clk) disable iff (!rst_n)
        $rose(action_valid) |-> since_accept == exp_latency)
        else report_mismatch("action_valid delay", 64'(exp_latency), 64'(since_accept));
    a_action: assert property (@(negedge clk) disable iff (!rst_n)
        action_valid |-> action == exp_action)
        else report_mismatch("action", 64'(exp_action), 64'(action));
    a_phv: assert property (@(negedge clk) disable iff (!rst_n)
        action_valid |-> phv_out == exp_phv)
        else report_mismatch("phv_out", exp_phv, phv_out);
    a_busy: assert property (@(negedge clk) disable iff (!rst_n)
        action_valid |-> !ready_out)
        else report_mismatch("ready_out", 64'd0, 64'(ready_out));
    a_hold: assert property (@(negedge clk) disable iff (!rst_n)
        action_valid && !ready_in |=> action_valid && $stable(action) && $stable(phv_out))
        else report_problem("output changed while ready_in was low");
    a_take: assert property (@(negedge clk) disable iff (!rst_n)
        action_valid && ready_in |=> !action_valid && ready_out)
        else report_problem("output was not released after one transfer");
    a_fwd_valid: assert property (@(negedge clk) disable iff (!rst_n)
        cfg_out_valid == exp_out_valid)
        else report_mismatch("cfg_out_valid", 64'(exp_out_valid), 64'(cfg_out_valid));
    a_fwd_data: assert property (@(negedge clk) disable iff (!rst_n)
        exp_out_valid |-> cfg_out_data == exp_out_data)
        else report_mismatch("cfg_out_data", exp_out_data, cfg_out_data);
    a_fwd_last: assert property (@(negedge clk) disable iff (!rst_n)
        exp_out_valid |-> cfg_out_last == exp_out_last)
        else report_mismatch("cfg_out_last", 64'(exp_out_last), 64'(cfg_out_last));

    task automatic send_beat(input cfg_t data, input logic last, input logic foreign);
        @(posedge clk);
        cfg_in_valid   <= 1'b1;
        cfg_in_data    <= data;
        cfg_in_last    <= last;
        cfg_in_foreign <= foreign;
    endtask

    task automatic end_packet();
        @(posedge clk);
        cfg_in_valid <= 1'b0;
        cfg_in_last  <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // header, then one data beat per entry from words[]
    task automatic write_entries(input logic [3:0] kind, input idx_t start, input int count);
        idx_t idx;
        send_beat({CTRL_FLAG, MOD_ID, kind, start, 32'h0}, 1'b0, 1'b0);
        for (int i = 0; i < count; i++) begin
            idx = start + idx_t'(i);
            send_beat({32'h0, words[i]}, i == count - 1, 1'b0);
            if (kind == 4'd0) begin
                model_key[idx]   = words[i];
                model_valid[idx] = 1'b1;
            end else begin
                model_act[idx] = words[i];
            end
        end
        end_packet();
    endtask

    // key and mask stay on the bus while the encoder registers the match
    task automatic lookup(input key_t key, input key_t mask, input int hold_cycles);
        logic hit;
        idx_t idx;
        phv_t phv;
        int   waited;
        phv = {next_rand(), next_rand()};
        predict(key, mask, hit, idx);
        @(posedge clk);
        key_valid   <= 1'b1;
        search_key  <= key;
        search_mask <= mask;
        phv_in      <= phv;
        ready_in    <= (hold_cycles == 0);
        exp_phv     <= phv;
        exp_action  <= hit ? model_act[idx] : DEFAULT_ACT;
        exp_latency <= hit ? 8'd3 : 8'd2;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!ready_out && waited < WAIT_LIMIT);
        if (!ready_out) begin
            report_problem("lookup key was never accepted");
        end
        key_valid <= 1'b0;
        // phv_out has to come from the capture register from here on
        phv_in    <= ~phv;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!action_valid && waited < WAIT_LIMIT);
        if (!action_valid) begin
            report_problem("no action came back for an accepted key");
        end
        if (hold_cycles > 0) begin
            // new key moves the match result underneath the held output
            search_key <= ~key;
            repeat (hold_cycles) @(posedge clk);
            ready_in <= 1'b1;
            @(posedge clk);
        end
    endtask

    initial begin
        key_t k;
        key_t m;
        lcg_state = 32'h9fc0;
        for (int i = 0; i < DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        key_valid      <= 1'b0;
        search_key     <= '0;
        search_mask    <= '0;
        phv_in         <= '0;
        ready_in       <= 1'b0;
        cfg_in_valid   <= 1'b0;
        cfg_in_data    <= '0;
        cfg_in_last    <= 1'b0;
        cfg_in_foreign <= 1'b0;
        wait (rst_n);
        @(negedge clk);

        // state right after reset
        assert (!action_valid) else report_mismatch("action_valid", 64'd0, 64'(action_valid));
        assert (!cfg_out_valid) else report_mismatch("cfg_out_valid", 64'd0, 64'(cfg_out_valid));
        assert (ready_out) else report_mismatch("ready_out", 64'd1, 64'(ready_out));

        // empty tables give the miss action
        lookup(next_rand(), next_rand(), 0);

        // three keys and three actions from index 4
        for (int i = 0; i < 3; i++) begin
            words[i] = next_rand();
        end
        write_entries(4'd0, 4'd4, 3);
        for (int i = 0; i < 3; i++) begin
            words[i] = next_rand();
        end
        write_entries(4'd1, 4'd4, 3);
        m = next_rand() | 32'hffff_0000;
        lookup(model_key[5] ^ (next_rand() & ~m), m, 0);
        lookup(model_key[5] ^ 32'h8000_0000, m, 0);

        // entries 8 and 9 differ only below the mask
        k = next_rand();
        words[0] = k;
        words[1] = k ^ 32'h0000_00a5;
        write_entries(4'd0, 4'd8, 2);
        words[0] = next_rand();
        words[1] = next_rand();
        write_entries(4'd1, 4'd8, 2);
        lookup(k ^ 32'h0000_0011, 32'hffff_ff00, 0);

        // back-pressure on the result
        lookup(model_key[6], 32'hffff_ffff, 6);

        // wrong flag, with a beat inside that looks like one of our headers
        send_beat({16'hf2f0, MOD_ID, 4'd0, 4'd1, next_rand()}, 1'b0, 1'b1);
        send_beat({CTRL_FLAG, MOD_ID, 4'd0, 4'd2, 32'h0}, 1'b0, 1'b1);
        send_beat({next_rand(), next_rand()}, 1'b1, 1'b1);
        words[0] = next_rand();
        write_entries(4'd1, 4'd5, 1);
        // next stage's module id
        send_beat({CTRL_FLAG, MOD_ID ^ 8'h08, 4'd1, 4'd0, next_rand()}, 1'b0, 1'b1);
        send_beat({32'h0, next_rand()}, 1'b1, 1'b1);
        end_packet();
        lookup(model_key[5], 32'hffff_ffff, 0);

        repeat (4) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        report_problem("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire
